// File: test/la_host_link_input.txt
# send / expect: hex bytes to the link / from the link; enable v; valids n (settings_valid total)
# word field hhhhhhhh: a settings field, checked once the link is idle
send 4C 50 0D 4C 51 0D 4C 45 31 0D
expect 53 4F 0A 0D 53 58 0A 0D 53 4F 0A 0D
enable 1
send 4C 57 31 32 33 34 41 42 43 44 46 46 30 30 46 46 30 30
send 30 30 30 30 30 30 31 30 38 30 30 30 30 30 30 46 0D
expect 53 4F 0A 0D
valids 1
enable 0
word trigger 1234ABCD
word trigger_mask FF00FF00
word trigger_after 00000010
word repeat_count 8000000F
send 4C 45 31 0D 4C 47 0D 4C 45 5A 0D
expect 53 4F 0A 0D 53 4F 31 0A 0D 53 58 0A 0D
enable 1
send 4C 45 0D 50 0D 4C 50 0D
expect 53 4F 0A 0D
send 4C 50 0D 4C 47 0D 4C 51 0D 4C 50 0D 4C 47 0D
expect 53 4F 0A 0D 53 4F 31 0A 0D 53 58 0A 0D 53 4F 0A 0D 53 4F 31 0A 0D
valids 1
enable 1

// File: la_host_link.f
hw/la_link_pkg.sv
hw/sync_fifo.sv
hw/cmd_parser.sv
hw/resp_writer.sv
hw/la_host_link.sv
test/la_host_link_asserts.sv
test/la_host_link_tb.sv

// File: Makefile
TOOL     := verilator
TOP      := la_host_link_tb
FILELIST := la_host_link.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
SIM      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'test passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/la_host_link_tb.sv
/*
 * Testbench for the host command link. Host bytes, expected response bytes
 * and expected enable and settings values come from the input data file.
 * Run from the project root so the data file path resolves.
 */
`timescale 1ns/1ns
`default_nettype none

module la_host_link_tb import la_link_pkg::*;;

  localparam int rx_depth   = 8;
  localparam int resp_depth = 4;
  localparam int tx_credits = 4;

  logic         clk = 1'b0;
  logic         rst;
  logic [7:0]   rx_byte;
  logic         rx_valid;
  logic         rx_credit;
  logic [7:0]   tx_byte;
  logic         tx_valid;
  logic         tx_credit;
  la_settings_t settings;
  logic         settings_valid;
  logic         enable;

  logic [7:0] send_q[$];
  logic [7:0] exp_q[$];
  int         due_q[$];
  string      lines[$];
  int         host_credits = rx_depth;
  int         cyc = 0;
  int         cycle_limit = 1000;
  int         errors = 0;
  int         checks = 0;
  int         valid_count = 0;

  la_host_link #(
    .RX_DEPTH   (rx_depth),
    .RESP_DEPTH (resp_depth),
    .TX_CREDITS (tx_credits)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .rx_credit      (rx_credit),
    .tx_byte        (tx_byte),
    .tx_valid       (tx_valid),
    .tx_credit      (tx_credit),
    .settings       (settings),
    .settings_valid (settings_valid),
    .enable         (enable)
  );

  always #4 clk = ~clk;

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  function automatic int hex_digit(input byte c);
    int v;
    v = int'(c);
    if (v >= 48 && v <= 57) return v - 48;
    if (v >= 65 && v <= 70) return v - 55;
    if (v >= 97 && v <= 102) return v - 87;
    return -1;
  endfunction

  // two-digit hex tokens after the keyword go to the host or expect queue
  task automatic queue_bytes(input string text, input int start, input bit to_link);
    string      padded;
    int         i;
    int         d;
    int         ndig;
    logic [7:0] value;
    padded = {text, " "};
    ndig = 0;
    value = 8'h00;
    for (i = start; i < padded.len(); i++) begin
      d = hex_digit(padded[i]);
      if (d >= 0) begin
        value = {value[3:0], 4'(d)};
        ndig++;
      end else if (ndig != 0) begin
        if (to_link) send_q.push_back(value);
        else exp_q.push_back(value);
        ndig = 0;
        value = 8'h00;
      end
    end
  endtask

  // sample outputs at the falling edge and then drive inputs for one cycle
  task automatic step();
    logic got_rx_credit;
    int   found;
    @(negedge clk);
    cyc++;
    if (cyc >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d host bytes and %0d response bytes still pending",
               cyc, send_q.size(), exp_q.size());
      $display("test failed");
      $finish;
    end else begin
      got_rx_credit = rx_credit;
      if (got_rx_credit && host_credits >= rx_depth) begin
        $display("rx_credit pulsed with no host byte outstanding");
        errors++;
      end
      if (settings_valid) valid_count++;
      if (tx_valid) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response byte %h with nothing left to expect", tx_byte);
          errors++;
        end else begin
          check("tx_byte", 32'(exp_q.pop_front()), 32'(tx_byte));
        end
        due_q.push_back(cyc + int'($urandom_range(5, 0)));
      end
      // host frees at most one slot per cycle
      found = -1;
      foreach (due_q[i]) begin
        if (found < 0 && due_q[i] <= cyc) found = i;
      end
      tx_credit = 1'b0;
      if (found >= 0) begin
        due_q.delete(found);
        tx_credit = 1'b1;
      end
      if (!rst && send_q.size() != 0 && host_credits != 0) begin
        rx_byte = send_q.pop_front();
        rx_valid = 1'b1;
        host_credits--;
      end else begin
        rx_valid = 1'b0;
      end
      // a returned credit is usable from the next cycle on
      if (got_rx_credit) host_credits++;
    end
  endtask

  // wait until all bytes are sent and consumed and all responses are seen
  task automatic drain();
    while (send_q.size() != 0 || host_credits != rx_depth || exp_q.size() != 0) begin
      step();
    end
  endtask

  initial begin
    string       line;
    string       kw;
    string       name;
    int          fd;
    logic [31:0] value;
    int          asrt_fails;
    rst = 1'b1;
    rx_byte = 8'h00;
    rx_valid = 1'b0;
    tx_credit = 1'b0;
    void'($urandom(32'h57f4));

    fd = $fopen("test/la_host_link_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the input data file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          if ($sscanf(line, "%s", kw) == 1 && kw[0] != "#") lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 200 * (lines.size() + 1) + 8;

    repeat (8) step();
    rst = 1'b0;

    foreach (lines[n]) begin
      void'($sscanf(lines[n], "%s", kw));
      case (kw)
        "send":   queue_bytes(lines[n], kw.len(), 1'b1);
        "expect": queue_bytes(lines[n], kw.len(), 1'b0);
        "enable": begin
          void'($sscanf(lines[n], "%s %h", kw, value));
          drain();
          check("enable", value, 32'(enable));
        end
        "valids": begin
          void'($sscanf(lines[n], "%s %d", kw, value));
          drain();
          check("settings_valid pulses", value, 32'(valid_count));
        end
        "word": begin
          void'($sscanf(lines[n], "%s %s %h", kw, name, value));
          drain();
          case (name)
            "trigger":       check("settings.trigger", value, settings.trigger);
            "trigger_mask":  check("settings.trigger_mask", value, settings.trigger_mask);
            "trigger_after": check("settings.trigger_after", value, settings.trigger_after);
            "repeat_count":  check("settings.repeat_count", value, settings.repeat_count);
            default: begin
              $display("unknown settings field %s in the input data file", name);
              errors++;
            end
          endcase
        end
        default: begin
          $display("unknown keyword %s in the input data file", kw);
          errors++;
        end
      endcase
    end

    drain();
    // quiet window to catch stray or repeated response bytes
    repeat (20) step();

    asrt_fails = UUT.u_writer.u_asserts.fail_count;
    if (asrt_fails != 0) begin
      $display("%0d assertion failures in the response writer", asrt_fails);
      errors += asrt_fails;
    end
    $display("errors %0d checks %0d", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/la_host_link_asserts.sv
/*
 * Credit rules of the response writer, bound into every resp_writer.
 * fail_count totals the assertion failures for the testbench summary.
 */
`timescale 1ns/1ns
`default_nettype none

module la_host_link_asserts #(
  parameter  int TX_CREDITS = 4,
  localparam int CRED_W     = $clog2(TX_CREDITS + 1)
) (
  input logic              clk,
  input logic              rst,
  input logic              tx_valid,
  input logic              tx_credit,
  input logic [CRED_W-1:0] credit_cnt
);

  int credit_fails = 0;
  int bound_fails = 0;
  int reset_fails = 0;
  int fail_count;
  int in_flight;

  assign fail_count = credit_fails + bound_fails + reset_fails;

  // bytes sent and not yet credited back by the host
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(tx_valid) - int'(tx_credit);
    end
  end

  // a byte goes out only against a held credit
  send_needs_credit: assert property (@(posedge clk) disable iff (rst)
    tx_valid |-> in_flight < TX_CREDITS)
    else begin
      $error("tx_valid asserted with zero credits");
      credit_fails++;
    end

  credit_in_range: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CRED_W'(TX_CREDITS))
    else begin
      $error("credit count above the host buffer size");
      bound_fails++;
    end

  quiet_after_reset: assert property (@(posedge clk) rst |=> !tx_valid)
    else begin
      $error("tx_valid high in the cycle after reset");
      reset_fails++;
    end

endmodule

bind resp_writer la_host_link_asserts #(.TX_CREDITS(TX_CREDITS)) u_asserts (
  .clk        (clk),
  .rst        (rst),
  .tx_valid   (tx_valid),
  .tx_credit  (tx_credit),
  .credit_cnt (credit_cnt)
);

`default_nettype wire

// File: hw/la_host_link.sv
/*
 * Host command link top level, byte streams in and out.
 * The host may send only while it holds a credit, starting with RX_DEPTH.
 * rx_credit pulses once per byte taken from the receive buffer.
 */
`timescale 1ns/1ns
`default_nettype none

module la_host_link import la_link_pkg::*; #(
  parameter int RX_DEPTH   = 8,
  parameter int RESP_DEPTH = 4,
  parameter int TX_CREDITS = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic [7:0]   rx_byte,
  input  logic         rx_valid,
  output logic         rx_credit,
  output logic [7:0]   tx_byte,
  output logic         tx_valid,
  input  logic         tx_credit,
  output la_settings_t settings,
  output logic         settings_valid,
  output logic         enable
);

  logic [7:0] rx_data;
  logic       rx_empty;
  logic       rx_pop;
  resp_t      resp_in;
  resp_t      resp_out;
  logic       resp_push;
  logic       resp_pop;
  logic       resp_empty;
  logic       resp_full;

  // every pop frees one slot on the host side
  assign rx_credit = rx_pop;

  // credits keep the host from overrunning this buffer
  sync_fifo #(.item_t(logic [7:0]), .DEPTH(RX_DEPTH)) rx_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (rx_valid),
    .push_data (rx_byte),
    .pop       (rx_pop),
    .pop_data  (rx_data),
    .empty     (rx_empty),
    .full      ()
  );

  cmd_parser u_parser (
    .clk            (clk),
    .rst            (rst),
    .rx_data        (rx_data),
    .rx_empty       (rx_empty),
    .rx_pop         (rx_pop),
    .resp_full      (resp_full),
    .resp_push      (resp_push),
    .resp           (resp_in),
    .settings       (settings),
    .settings_valid (settings_valid),
    .enable         (enable)
  );

  sync_fifo #(.item_t(resp_t), .DEPTH(RESP_DEPTH)) resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (resp_push),
    .push_data (resp_in),
    .pop       (resp_pop),
    .pop_data  (resp_out),
    .empty     (resp_empty),
    .full      (resp_full)
  );

  resp_writer #(.TX_CREDITS(TX_CREDITS)) u_writer (
    .clk        (clk),
    .rst        (rst),
    .resp_empty (resp_empty),
    .resp       (resp_out),
    .resp_pop   (resp_pop),
    .tx_byte    (tx_byte),
    .tx_valid   (tx_valid),
    .tx_credit  (tx_credit)
  );

endmodule

`default_nettype wire

// File: hw/resp_writer.sv
/*
 * Response serializer: 'S', status, optional argument, LF, CR.
 * The host must start with TX_CREDITS free slots and return exactly one
 * tx_credit per byte it consumes. The queue head is popped after the CR.
 */
`timescale 1ns/1ns
`default_nettype none

module resp_writer import la_link_pkg::*; #(
  parameter int TX_CREDITS = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       resp_empty,
  input  resp_t      resp,
  output logic       resp_pop,
  output logic [7:0] tx_byte,
  output logic       tx_valid,
  input  logic       tx_credit
);

  localparam int CRED_W = $clog2(TX_CREDITS + 1);

  typedef enum logic [2:0] {
    wr_idle,
    wr_id,
    wr_status,
    wr_arg,
    wr_lf,
    wr_cr
  } wr_state_t;

  wr_state_t         state;
  logic [CRED_W-1:0] credit_cnt;

  // one byte per cycle while the host has room
  assign tx_valid = (state != wr_idle) && (credit_cnt != '0);
  assign resp_pop = tx_valid && (state == wr_cr);

  always_comb begin
    case (state)
      wr_id:     tx_byte = resp_id_byte;
      wr_status: tx_byte = resp.status;
      wr_arg:    tx_byte = resp.arg;
      wr_lf:     tx_byte = line_feed;
      wr_cr:     tx_byte = carriage_return;
      default:   tx_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= wr_idle;
      credit_cnt <= CRED_W'(TX_CREDITS);
    end else begin
      case ({tx_valid, tx_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase

      if (state == wr_idle) begin
        if (!resp_empty) state <= wr_id;
      end else if (tx_valid) begin
        case (state)
          wr_id:     state <= wr_status;
          wr_status: state <= resp.has_arg ? wr_arg : wr_lf;
          wr_arg:    state <= wr_lf;
          wr_lf:     state <= wr_cr;
          default:   state <= wr_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cmd_parser.sv
/*
 * Host frame decoder: 'L', command, arguments, carriage return.
 * Non-hex characters inside a settings word decode as zero. A carriage
 * return before the argument bytes are complete drops the frame silently.
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_parser import la_link_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic [7:0]   rx_data,
  input  logic         rx_empty,
  output logic         rx_pop,
  input  logic         resp_full,
  output logic         resp_push,
  output resp_t        resp,
  output la_settings_t settings,
  output logic         settings_valid,
  output logic         enable
);

  typedef enum logic [2:0] {
    st_idle,
    st_command,
    st_enable_arg,
    st_trigger,
    st_trigger_mask,
    st_trigger_after,
    st_repeat_count,
    st_wait_cr
  } state_t;

  state_t       state;
  logic [2:0]   digit_cnt;
  la_settings_t shadow;
  logic [7:0]   resp_status;
  logic         resp_has_arg;
  logic [7:0]   resp_arg;
  logic [3:0]   nib;
  logic         is_cr;
  logic         frame_done;
  logic         last_digit;

  // ascii hex digit to nibble
  function automatic logic [3:0] hex_nibble(input logic [7:0] b);
    logic [7:0] v;
    v = 8'h00;
    if (b >= "0" && b <= "9") begin
      v = b - "0";
    end else if (b >= "A" && b <= "F") begin
      v = b - "A" + 8'd10;
    end
    return v[3:0];
  endfunction

  assign nib        = hex_nibble(rx_data);
  assign is_cr      = (rx_data == carriage_return);
  assign last_digit = (digit_cnt == 3'(word_digits - 1));
  assign frame_done = (state == st_wait_cr) && is_cr;

  // hold the closing CR in the FIFO until the queue has room
  assign rx_pop    = !rx_empty && !(frame_done && resp_full);
  assign resp_push = rx_pop && frame_done;
  assign resp      = '{status: resp_status, has_arg: resp_has_arg, arg: resp_arg};

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= st_idle;
      digit_cnt      <= '0;
      settings       <= '0;
      settings_valid <= 1'b0;
      enable         <= 1'b0;
    end else begin
      settings_valid <= 1'b0;
      if (rx_pop) begin
        if (is_cr && state != st_wait_cr) begin
          // early CR, frame dropped
          state <= st_idle;
        end else begin
          case (state)
            st_idle: begin
              if (rx_data == start_byte) begin
                state <= st_command;
              end
            end
            st_command: begin
              resp_has_arg <= 1'b0;
              resp_status  <= status_ok;
              state        <= st_wait_cr;
              case (rx_data)
                cmd_ping: ;
                cmd_write_settings: begin
                  // capture core stays off while settings change
                  enable    <= 1'b0;
                  digit_cnt <= '0;
                  state     <= st_trigger;
                end
                cmd_set_enable: state <= st_enable_arg;
                cmd_get_enable: begin
                  resp_has_arg <= 1'b1;
                  resp_arg     <= hex_zero_byte + 8'(enable);
                end
                default: resp_status <= status_fail;
              endcase
            end
            st_enable_arg: begin
              if (rx_data == hex_zero_byte || rx_data == hex_zero_byte + 8'd1) begin
                enable <= rx_data[0];
              end else begin
                resp_status <= status_fail;
              end
              state <= st_wait_cr;
            end
            st_trigger: begin
              shadow.trigger <= {shadow.trigger[27:0], nib};
              digit_cnt      <= digit_cnt + 1'b1;
              if (last_digit) state <= st_trigger_mask;
            end
            st_trigger_mask: begin
              shadow.trigger_mask <= {shadow.trigger_mask[27:0], nib};
              digit_cnt           <= digit_cnt + 1'b1;
              if (last_digit) state <= st_trigger_after;
            end
            st_trigger_after: begin
              shadow.trigger_after <= {shadow.trigger_after[27:0], nib};
              digit_cnt            <= digit_cnt + 1'b1;
              if (last_digit) state <= st_repeat_count;
            end
            st_repeat_count: begin
              shadow.repeat_count <= {shadow.repeat_count[27:0], nib};
              digit_cnt           <= digit_cnt + 1'b1;
              if (last_digit) begin
                // all four words land together
                settings       <= '{trigger:       shadow.trigger,
                                    trigger_mask:  shadow.trigger_mask,
                                    trigger_after: shadow.trigger_after,
                                    repeat_count:  {shadow.repeat_count[27:0], nib}};
                settings_valid <= 1'b1;
                state          <= st_wait_cr;
              end
            end
            st_wait_cr: begin
              // other bytes are skipped until the CR
              if (is_cr) state <= st_idle;
            end
            default: state <= st_idle;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
/*
 * Show-ahead synchronous FIFO. pop_data is valid whenever empty is low.
 * A push while full and a pop while empty are dropped, so callers must
 * respect the flags or a credit scheme that keeps them in range.
 */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  item_t push_data,
  input  logic  pop,
  output item_t pop_data,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/la_link_pkg.sv
/*
 * Shared definitions for the logic analyzer host command link.
 * All protocol bytes are ASCII. Settings words travel as eight upper-case
 * hex digits, most significant digit first.
 */
`default_nettype none

package la_link_pkg;

  // framing bytes
  localparam logic [7:0] start_byte      = "L";
  localparam logic [7:0] resp_id_byte    = "S";
  localparam logic [7:0] line_feed       = 8'h0A;
  localparam logic [7:0] carriage_return = 8'h0D;

  // response status codes
  localparam logic [7:0] status_ok       = "O";
  localparam logic [7:0] status_fail     = "X";

  // base for digit encoding, also the '0' enable argument
  localparam logic [7:0] hex_zero_byte   = "0";

  localparam int word_digits = 8;

  typedef enum logic [7:0] {
    cmd_ping           = "P",
    cmd_write_settings = "W",
    cmd_set_enable     = "E",
    cmd_get_enable     = "G"
  } cmd_code_t;

  // capture core settings, in the order they arrive on the wire
  typedef struct packed {
    logic [31:0] trigger;
    logic [31:0] trigger_mask;
    logic [31:0] trigger_after;
    logic [31:0] repeat_count;
  } la_settings_t;

  // one queued response, arg only sent when has_arg is set
  typedef struct packed {
    logic [7:0] status;
    logic       has_arg;
    logic [7:0] arg;
  } resp_t;

endpackage

`default_nettype wire
